/* rtl/uart_cmd_pkg.sv */
`default_nettype none

package uart_cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [15:0] cmd_word_t;   // Host command word.
  typedef logic [7:0]  uart_byte_t;  // One serial data byte.
  typedef logic [15:0] baud_div_t;   // Clocks per bit.
  typedef logic [7:0]  bit_time_t;   // Duration in bit times.
  typedef logic [1:0]  cfg_addr_t;   // Configuration register select.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam cfg_addr_t CFG_ADDR_BAUD    = 2'd0;
  localparam cfg_addr_t CFG_ADDR_GAP     = 2'd1;
  localparam cfg_addr_t CFG_ADDR_TIMEOUT = 2'd2;

  localparam baud_div_t MIN_BAUD_DIV = 16'd4;  // Keeps half-bit sampling meaningful.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command and frame layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int CMD_WRITE_BIT = 15;  // Set for write, clear for read.

  // Start, eight data, parity and stop.
  localparam logic [3:0] FRAME_BITS    = 4'd11;
  localparam logic [2:0] LAST_DATA_BIT = 3'd7;

endpackage

`default_nettype wire

/* rtl/uart_frame_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface uart_frame_if (
  input logic clk
);

  logic                     tx_start;
  uart_cmd_pkg::uart_byte_t tx_data;
  logic                     tx_busy;

  logic                     rx_arm;
  logic                     rx_busy;
  logic                     rx_valid;
  uart_cmd_pkg::uart_byte_t rx_data;
  logic                     rx_err;  // Parity or stop fault.

  modport seq (
    input  clk, tx_busy, rx_busy, rx_valid, rx_data, rx_err,
    output tx_start, tx_data, rx_arm
  );

  modport tx (
    input  clk, tx_start, tx_data,
    output tx_busy
  );

  modport rx (
    input  clk, rx_arm,
    output rx_busy, rx_valid, rx_data, rx_err
  );

endinterface

`default_nettype wire

/* rtl/uart_cmd_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_cfg #(
  parameter uart_cmd_pkg::baud_div_t DEFAULT_BAUD_DIV = 16'd434,
  parameter uart_cmd_pkg::bit_time_t DEFAULT_GAP      = 8'd100,
  parameter uart_cmd_pkg::bit_time_t DEFAULT_TIMEOUT  = 8'd40
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       cfg_wr,
  input  uart_cmd_pkg::cfg_addr_t   cfg_addr,
  input  uart_cmd_pkg::baud_div_t   cfg_wdata,
  input  wire                       cmd_rdy,
  output uart_cmd_pkg::baud_div_t   baud_div,
  output uart_cmd_pkg::bit_time_t   gap_len,
  output uart_cmd_pkg::bit_time_t   reply_timeout
);

  logic wr_en;

  assign wr_en = cfg_wr & cmd_rdy;  // Writes land only between commands.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      baud_div      <= DEFAULT_BAUD_DIV;
      gap_len       <= DEFAULT_GAP;
      reply_timeout <= DEFAULT_TIMEOUT;
    end
    else if (wr_en)
    begin
      case (cfg_addr)
        uart_cmd_pkg::CFG_ADDR_BAUD:    baud_div      <= cfg_wdata;
        uart_cmd_pkg::CFG_ADDR_GAP:     gap_len       <= cfg_wdata[7:0];
        uart_cmd_pkg::CFG_ADDR_TIMEOUT: reply_timeout <= cfg_wdata[7:0];
        default: ;  // Address 3 is unmapped.
      endcase
    end
  end

  // Host must never program a divisor too small for mid-bit sampling.
  baud_div_min_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    baud_div >= uart_cmd_pkg::MIN_BAUD_DIV
  );

endmodule

`default_nettype wire

/* rtl/uart_tx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame (
  input  wire                     clk,
  input  wire                     rst_n,
  input  uart_cmd_pkg::baud_div_t baud_div,
  uart_frame_if.tx                frm,
  output logic                    tx
);

  logic                    busy;
  logic [10:0]             frame;    // Stop, parity, data, start from MSB down.
  logic [3:0]              bit_cnt;
  uart_cmd_pkg::baud_div_t clk_cnt;
  logic                    bit_tick;

  assign bit_tick    = (clk_cnt == baud_div - 1'b1);
  assign frm.tx_busy = busy;

  // Odd parity over data plus parity bit.
  always_ff @(posedge clk)
  begin
    if (frm.tx_start)
    begin
      frame <= {1'b1, ~^frm.tx_data, frm.tx_data, 1'b0};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (frm.tx_start)
    begin
      busy    <= 1'b1;
      clk_cnt <= baud_div - 1'b1;  // First tick one clock later puts out the start bit.
      bit_cnt <= '0;
    end
    else if (busy)
    begin
      if (bit_tick)
      begin
        clk_cnt <= '0;
        if (bit_cnt == uart_cmd_pkg::FRAME_BITS)
        begin
          busy <= 1'b0;  // Stop bit has now lasted a full bit time.
          tx   <= 1'b1;
        end
        else
        begin
          tx      <= frame[bit_cnt];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
      begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // A start request during a frame would be silently lost.
  tx_start_idle_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    frm.tx_start |-> !frm.tx_busy
  );

endmodule

`default_nettype wire

/* rtl/uart_rx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     rx,
  input  uart_cmd_pkg::baud_div_t baud_div,
  uart_frame_if.rx                frm
);

  typedef enum logic [2:0] {
    st_wait,
    st_start,
    st_data,
    st_parity,
    st_stop
  } rx_state_t;

  rx_state_t                state;
  logic                     rx_s1;
  logic                     rx_s2;
  logic                     rx_hist;
  uart_cmd_pkg::baud_div_t  clk_cnt;
  logic [2:0]               bit_idx;
  uart_cmd_pkg::uart_byte_t shreg;
  logic                     par_bit;
  logic                     fall;
  logic                     sample;
  logic                     judge;

  assign fall   = rx_hist & ~rx_s2;
  // Start bit is checked at half a bit, later bits one full bit apart.
  assign sample = (state == st_start) ? (clk_cnt == (baud_div >> 1))
                                      : (clk_cnt == baud_div - 1'b1);
  assign judge  = (state == st_stop) && sample;

  assign frm.rx_busy = (state != st_wait);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1   <= 1'b1;  // Idle line.
      rx_s2   <= 1'b1;
      rx_hist <= 1'b1;
    end
    else
    begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_hist <= rx_s2;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= st_wait;
      clk_cnt      <= '0;
      bit_idx      <= '0;
      frm.rx_valid <= 1'b0;
    end
    else
    begin
      frm.rx_valid <= judge;
      clk_cnt      <= (sample || state == st_wait) ? '0 : clk_cnt + 1'b1;
      case (state)
        st_wait:   if (frm.rx_arm && fall) state <= st_start;
        st_start:
        begin
          bit_idx <= '0;
          if (sample) state <= rx_s2 ? st_wait : st_data;  // High again means a glitch.
        end
        st_data:
        begin
          if (sample)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == uart_cmd_pkg::LAST_DATA_BIT) state <= st_parity;
          end
        end
        st_parity: if (sample) state <= st_stop;
        st_stop:   if (sample) state <= st_wait;
        default:   state <= st_wait;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_data && sample) shreg <= {rx_s2, shreg[7:1]};  // LSB first.
    if (state == st_parity && sample) par_bit <= rx_s2;
    if (judge)
    begin
      frm.rx_data <= shreg;
      frm.rx_err  <= ~(^{shreg, par_bit}) | ~rx_s2;
    end
  end

  rx_valid_pulse_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    frm.rx_valid |=> !frm.rx_valid
  );

endmodule

`default_nettype wire

/* rtl/uart_cmd_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_seq (
  input  wire                        clk,
  input  wire                        rst_n,
  input  uart_cmd_pkg::cmd_word_t    cmd_in,
  input  wire                        cmd_vld,
  input  uart_cmd_pkg::baud_div_t    baud_div,
  input  uart_cmd_pkg::bit_time_t    gap_len,
  input  uart_cmd_pkg::bit_time_t    reply_timeout,
  uart_frame_if.seq                  frm,
  output logic                       cmd_rdy,
  output logic                       read_vld,
  output uart_cmd_pkg::uart_byte_t   read_data,
  output logic                       read_err
);

  typedef enum logic [3:0] {
    idle,
    send_hi,
    wait_hi,
    send_lo,
    wait_lo,
    gap,
    listen,
    receive,
    report
  } seq_state_t;

  seq_state_t              state;
  seq_state_t              state_nxt;
  uart_cmd_pkg::cmd_word_t cmd_q;
  uart_cmd_pkg::baud_div_t clk_cnt;
  uart_cmd_pkg::bit_time_t bt_cnt;
  logic                    busy_q;
  logic                    tx_done;
  logic                    bit_tick;
  logic                    timing;

  assign cmd_rdy  = (state == idle) || (state == report);
  assign read_vld = (state == report);
  assign tx_done  = busy_q & ~frm.tx_busy;  // Falling edge ends a frame.
  assign bit_tick = (clk_cnt == baud_div - 1'b1);
  assign timing   = (state == gap) || (state == listen);

  assign frm.tx_start = (state == send_hi) || (state == send_lo);
  assign frm.tx_data  = (state == send_lo) ? cmd_q[7:0] : cmd_q[15:8];
  assign frm.rx_arm   = (state == listen);

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy) cmd_q <= cmd_in;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    state_nxt = state;
    case (state)
      idle, report: state_nxt = cmd_vld ? send_hi : idle;
      send_hi:      state_nxt = wait_hi;
      wait_hi:
      begin
        if (tx_done) state_nxt = cmd_q[uart_cmd_pkg::CMD_WRITE_BIT] ? send_lo : gap;
      end
      send_lo:      state_nxt = wait_lo;
      wait_lo:      if (tx_done) state_nxt = idle;
      gap:          if (bt_cnt == gap_len) state_nxt = listen;
      listen:
      begin
        if (frm.rx_busy) state_nxt = receive;  // Timeout stops once a frame starts.
        else if (bt_cnt == reply_timeout) state_nxt = report;
      end
      receive:
      begin
        if (frm.rx_valid) state_nxt = report;
        else if (!frm.rx_busy) state_nxt = listen;  // Receiver dropped a glitch.
      end
      default:      state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= idle;
      busy_q    <= 1'b0;
      clk_cnt   <= '0;
      bt_cnt    <= '0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      state  <= state_nxt;
      busy_q <= frm.tx_busy;
      if (!timing || state_nxt != state)
      begin
        clk_cnt <= '0;  // Each timed phase starts from zero.
        bt_cnt  <= '0;
      end
      else
      begin
        clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
        bt_cnt  <= bt_cnt + {7'd0, bit_tick};
      end
      if (state == listen && state_nxt == report)
      begin
        read_data <= '0;
        read_err  <= 1'b1;
      end
      else if (state == receive && frm.rx_valid)
      begin
        read_data <= frm.rx_data;
        read_err  <= frm.rx_err;
      end
    end
  end

  read_vld_pulse_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld
  );

  // Receiver must never listen while our own frame is on the line.
  no_arm_during_tx_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    frm.tx_busy |-> !frm.rx_arm
  );

endmodule

`default_nettype wire

/* rtl/uart_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top #(
  parameter uart_cmd_pkg::baud_div_t DEFAULT_BAUD_DIV = 16'd434,
  parameter uart_cmd_pkg::bit_time_t DEFAULT_GAP      = 8'd100,
  parameter uart_cmd_pkg::bit_time_t DEFAULT_TIMEOUT  = 8'd40
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  uart_cmd_pkg::cmd_word_t   cmd_in,
  input  wire                       cmd_vld,
  input  wire                       rx,
  input  wire                       cfg_wr,
  input  uart_cmd_pkg::cfg_addr_t   cfg_addr,
  input  uart_cmd_pkg::baud_div_t   cfg_wdata,
  output logic                      cmd_rdy,
  output logic                      tx,
  output logic                      read_vld,
  output uart_cmd_pkg::uart_byte_t  read_data,
  output logic                      read_err
);

  uart_cmd_pkg::baud_div_t baud_div;
  uart_cmd_pkg::bit_time_t gap_len;
  uart_cmd_pkg::bit_time_t reply_timeout;

  uart_frame_if frm_if (.clk(clk));

  uart_cmd_cfg #(
    .DEFAULT_BAUD_DIV (DEFAULT_BAUD_DIV),
    .DEFAULT_GAP      (DEFAULT_GAP),
    .DEFAULT_TIMEOUT  (DEFAULT_TIMEOUT)
  ) uart_cmd_cfg_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cmd_rdy       (cmd_rdy),
    .baud_div      (baud_div),
    .gap_len       (gap_len),
    .reply_timeout (reply_timeout)
  );

  uart_cmd_seq uart_cmd_seq_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .baud_div      (baud_div),
    .gap_len       (gap_len),
    .reply_timeout (reply_timeout),
    .frm           (frm_if.seq),
    .cmd_rdy       (cmd_rdy),
    .read_vld      (read_vld),
    .read_data     (read_data),
    .read_err      (read_err)
  );

  uart_tx_frame uart_tx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .baud_div (baud_div),
    .frm      (frm_if.tx),
    .tx       (tx)
  );

  uart_rx_frame uart_rx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .baud_div (baud_div),
    .frm      (frm_if.rx)
  );

endmodule

`default_nettype wire

/* sim/tb_uart_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd;

  localparam int NUM_VEC      = 16;
  localparam int GAP_BITS     = 3;
  localparam int TIMEOUT_BITS = 8;

  logic                     clk = 1'b0;
  logic                     rst_n;
  uart_cmd_pkg::cmd_word_t  cmd_in;
  logic                     cmd_vld;
  logic                     rx;
  logic                     cfg_wr;
  uart_cmd_pkg::cfg_addr_t  cfg_addr;
  uart_cmd_pkg::baud_div_t  cfg_wdata;
  logic                     cmd_rdy;
  logic                     tx;
  logic                     read_vld;
  uart_cmd_pkg::uart_byte_t read_data;
  logic                     read_err;

  logic [15:0] vec_mem [0:NUM_VEC*4-1];  // Four words per test.
  int          errors    = 0;
  int          passed    = 0;
  int          failed    = 0;
  int          rvld_cnt  = 0;
  int          quiet_bad = 0;
  logic        quiet_on  = 1'b0;
  integer      seed      = 4262;

  uart_cmd_top uart_cmd_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  always #10 clk = ~clk;

  always @(negedge clk)
  begin
    if (read_vld === 1'b1) rvld_cnt++;
    if (quiet_on && tx !== 1'b1) quiet_bad++;  // Line must stay idle in the window.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reporting and frame rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic report_mismatch(input string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs0);
    if (errors == errs0)
    begin
      passed++;
      $display("PASS %s", name);
    end
    else
    begin
      failed++;
      $display("FAIL %0t ns: %s had %0d errors", $time, name, errors - errs0);
    end
  endtask

  // Data plus parity must hold an odd number of ones.
  function automatic logic odd_parity_bit(input logic [7:0] d);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++)
    begin
      if (d[i]) ones++;
    end
    return (ones % 2 == 0);
  endfunction

  // Bits the line stays low for, counting from the start bit.
  function automatic int zero_run_bits(input logic [7:0] d);
    logic [10:0] bits;
    int          n;
    bits = {1'b1, odd_parity_bit(d), d, 1'b0};
    n = 0;
    while (n < 11 && bits[n] == 1'b0) n++;
    return n;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic write_cfg(input uart_cmd_pkg::cfg_addr_t addr, input int value);
    cfg_addr  = addr;
    cfg_wdata = value[15:0];
    cfg_wr    = 1'b1;
    @(negedge clk);
    cfg_wr    = 1'b0;
  endtask

  task automatic send_cmd(input logic [15:0] cmd);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_ready(input int limit);
    int t;
    t = 0;
    while (cmd_rdy !== 1'b1 && t < limit)
    begin
      @(negedge clk);
      t++;
    end
    if (cmd_rdy !== 1'b1) report_timeout($sformatf("cmd_rdy stayed low for %0d clocks", limit));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Serial peer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Returns on the last mid-cycle of the stop bit.
  task automatic expect_frame(input int div, input logic [7:0] exp, input string tag);
    logic [10:0] bits;
    logic        run_open;
    int          low_run;
    int          i;
    int          t;
    t = 0;
    while (tx !== 1'b0 && t < 16 * div)
    begin
      @(negedge clk);
      t++;
    end
    if (tx !== 1'b0)
    begin
      report_timeout($sformatf("no %s frame started on tx", tag));
    end
    else
    begin
      bits     = '1;
      low_run  = 0;
      run_open = 1'b1;
      for (i = 0; i < 11 * div; i++)
      begin
        if (run_open && tx === 1'b0) low_run++;
        else run_open = 1'b0;
        if (i % div == div / 2) bits[i / div] = tx;  // Mid-bit sample.
        if (i < 11 * div - 1) @(negedge clk);
      end
      if (bits[0] !== 1'b0) report_mismatch($sformatf("%s frame start bit high", tag));
      if (bits[8:1] !== exp)
        report_mismatch($sformatf("%s byte %02h, expected %02h", tag, bits[8:1], exp));
      if (bits[9] !== odd_parity_bit(exp))
        report_mismatch($sformatf("%s frame parity bit %b is not odd", tag, bits[9]));
      if (bits[10] !== 1'b1) report_mismatch($sformatf("%s frame stop bit low", tag));
      if (low_run != zero_run_bits(exp) * div)
        report_mismatch($sformatf("%s frame low for %0d clocks, expected %0d", tag,
                                  low_run, zero_run_bits(exp) * div));
    end
  endtask

  task automatic drive_reply(input logic [7:0] d, input logic bad_par, input int div);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, odd_parity_bit(d) ^ bad_par, d, 1'b0};
    for (i = 0; i < 11; i++)
    begin
      rx = bits[i];
      repeat (div) @(negedge clk);
    end
  endtask

  // Short low pulse, well under half a bit.
  task automatic drive_glitch(input int div);
    int w;
    w = ($random(seed) & 32'h7fff_ffff) % (div / 2 - 2) + 1;
    rx = 1'b0;
    repeat (w) @(negedge clk);
    rx = 1'b1;
    repeat (2 * div) @(negedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_write(input logic [15:0] cmd, input int div);
    int rvld0;
    int quiet0;
    rvld0 = rvld_cnt;
    send_cmd(cmd);
    fork
      begin
        expect_frame(div, cmd[15:8], "upper");
        expect_frame(div, cmd[7:0], "lower");
      end
      begin
        repeat (3 * div) @(negedge clk);
        send_cmd(~cmd);  // Arrives while busy.
      end
    join
    if (cmd_rdy !== 1'b0) report_mismatch("cmd_rdy high before the second stop bit ended");
    wait_ready(4);
    quiet0   = quiet_bad;
    quiet_on = 1'b1;
    repeat (2 * div) @(negedge clk);
    quiet_on = 1'b0;
    if (quiet_bad != quiet0) report_mismatch("extra frame on tx after the write");
    if (rvld_cnt != rvld0) report_mismatch("read_vld pulsed during a write");
  endtask

  task automatic run_read(input logic [15:0] cmd, input logic [7:0] reply, input int mode,
                          input int div);
    logic [7:0] exp_data;
    logic       exp_err;
    logic [7:0] got_data;
    logic       got_err;
    logic       got_rdy;
    int         limit;
    int         t;
    int         rvld0;
    int         quiet0;
    exp_data = (mode == 2) ? 8'h00 : reply;
    exp_err  = (mode == 1 || mode == 2);
    limit    = (mode == 2) ? (GAP_BITS + TIMEOUT_BITS + 4) * div
                           : (GAP_BITS + TIMEOUT_BITS + 20) * div;
    rvld0    = rvld_cnt;
    send_cmd(cmd);
    expect_frame(div, cmd[15:8], "request");
    quiet0   = quiet_bad;
    quiet_on = 1'b1;
    fork
      begin
        if (mode != 2)
        begin
          repeat ((GAP_BITS + 2) * div) @(negedge clk);
          if (mode == 3) drive_glitch(div);
          drive_reply(reply, mode == 1, div);
        end
      end
      begin
        t = 0;
        while (read_vld !== 1'b1 && t < limit)
        begin
          @(negedge clk);
          t++;
        end
        if (read_vld !== 1'b1)
        begin
          report_timeout($sformatf("read_vld did not pulse within %0d clocks", limit));
        end
        else
        begin
          got_data = read_data;
          got_err  = read_err;
          got_rdy  = cmd_rdy;
          @(negedge clk);
          if (got_data !== exp_data)
            report_mismatch($sformatf("read_data %02h, expected %02h", got_data, exp_data));
          if (got_err !== exp_err)
            report_mismatch($sformatf("read_err %b, expected %b", got_err, exp_err));
          if (got_rdy !== 1'b1) report_mismatch("cmd_rdy low in the read_vld cycle");
        end
      end
    join
    quiet_on = 1'b0;
    if (quiet_bad != quiet0) report_mismatch("tx left idle while the read was open");
    if (rvld_cnt - rvld0 != 1)
      report_mismatch($sformatf("read_vld pulsed %0d cycles, expected 1", rvld_cnt - rvld0));
  endtask

  task automatic run_cfg_drop(input int div_a, input int div_b);
    wait_ready(8);
    write_cfg(uart_cmd_pkg::CFG_ADDR_BAUD, div_a);
    send_cmd(16'h9A35);
    fork
      begin
        expect_frame(div_a, 8'h9A, "upper");
        expect_frame(div_a, 8'h35, "lower");
      end
      begin
        repeat (4) @(negedge clk);
        write_cfg(uart_cmd_pkg::CFG_ADDR_BAUD, div_b);  // Must be dropped.
      end
    join
    wait_ready(4);
    send_cmd(16'h8B4C);
    expect_frame(div_a, 8'h8B, "next upper");
    expect_frame(div_a, 8'h4C, "next lower");
    wait_ready(4);
  endtask

  initial
  begin
    int          errs0;
    int          v;
    int          mode;
    int          div;
    logic [15:0] cmd;
    string       name;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    $readmemh("sim/cmd_vectors.mem", vec_mem);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    errs0 = errors;
    @(negedge clk);
    if (tx !== 1'b1) report_mismatch("tx not idle high after reset");
    if (cmd_rdy !== 1'b1) report_mismatch("cmd_rdy low after reset");
    if (read_vld !== 1'b0) report_mismatch("read_vld high after reset");
    if (read_err !== 1'b0) report_mismatch("read_err high after reset");
    finish_test("reset state", errs0);

    write_cfg(uart_cmd_pkg::CFG_ADDR_GAP, GAP_BITS);  // Short gap keeps runs brief.
    write_cfg(uart_cmd_pkg::CFG_ADDR_TIMEOUT, TIMEOUT_BITS);

    for (v = 0; v < NUM_VEC; v++)
    begin
      errs0 = errors;
      cmd   = vec_mem[4 * v];
      mode  = int'(vec_mem[4 * v + 2]);
      div   = int'(vec_mem[4 * v + 3]);
      if (cmd[uart_cmd_pkg::CMD_WRITE_BIT]) name = $sformatf("vector %0d write %04h", v, cmd);
      else name = $sformatf("vector %0d read %04h mode %0d", v, cmd, mode);
      if (div < int'(uart_cmd_pkg::MIN_BAUD_DIV) || div < 8)
      begin
        $display("Vector %0d has an unusable baud divisor %0d", v, div);
        errors++;
      end
      else
      begin
        wait_ready(8);
        write_cfg(uart_cmd_pkg::CFG_ADDR_BAUD, div);
        if (cmd[uart_cmd_pkg::CMD_WRITE_BIT]) run_write(cmd, div);
        else run_read(cmd, vec_mem[4 * v + 1][7:0], mode, div);
      end
      finish_test(name, errs0);
    end

    errs0 = errors;
    run_cfg_drop(16, 24);
    finish_test("config write while busy is dropped", errs0);

    $display("Tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0 && errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/cmd_vectors.mem */
// Columns: command word, reply byte, reply mode, baud divisor (hex).
// Mode 0 good, 1 bad parity, 2 no reply, 3 glitch then good; writes ignore reply and mode.
8512 00 0 0010
A3C4 00 0 000C
FF00 00 0 0014
8001 00 0 0008
C27E 00 0 0018
1100 A5 0 0010
2200 3C 0 000C
7F00 00 0 0014
0400 FF 0 0008
3300 81 1 0010
4500 5A 1 0014
0A00 00 2 0010
6600 00 2 000C
1200 C3 3 0010
5C00 7E 3 0014
0100 99 3 0018

/* src.f */
rtl/uart_cmd_pkg.sv
rtl/uart_frame_if.sv
rtl/uart_cmd_cfg.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_seq.sv
rtl/uart_cmd_top.sv
sim/tb_uart_cmd.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_uart_cmd -o tb_uart_cmd -f src.f

out=$(./obj_dir/tb_uart_cmd)
echo "$out"

echo "$out" | grep -q "^TB PASSED$"
